// ==== hdl/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// ################################################
// Core dimensions
// ################################################
`define CPU_XLEN      32            // Data and address width
`define CPU_RADDR_W   5             // Register specifier width
`define CPU_NUM_REGS  32            // Architectural registers

// ################################################
// Boot
// ################################################
`define CPU_RESET_PC  32'h0000_0000 // First fetch address

`endif

// ==== hdl/cpu_pkg.sv ====
`include "cpu_settings.svh"
`default_nettype none

package cpu_pkg;

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_ORI     = 6'h0d,
    OP_LUI     = 6'h0f,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a
  } funct_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_LUI
  } alu_op_e;

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_LOAD,
    MEM_STORE
  } mem_op_e;

  typedef struct packed {
    logic                    valid;
    logic [`CPU_XLEN-1:0]    pc;
    logic [`CPU_XLEN-1:0]    instr;
    alu_op_e                 alu_op;
    mem_op_e                 mem_op;
    logic [`CPU_XLEN-1:0]    op_a;
    logic [`CPU_XLEN-1:0]    op_b;
    logic [`CPU_XLEN-1:0]    store_data;
    logic                    wreg;
    logic [`CPU_RADDR_W-1:0] waddr;
  } id_ex_t;

  typedef struct packed {
    logic                    valid;
    logic [`CPU_XLEN-1:0]    pc;
    logic [`CPU_XLEN-1:0]    instr;
    mem_op_e                 mem_op;
    logic [`CPU_XLEN-1:0]    result;     // ALU value or memory address
    logic [`CPU_XLEN-1:0]    store_data;
    logic                    wreg;
    logic [`CPU_RADDR_W-1:0] waddr;
  } ex_mem_t;

  typedef struct packed {
    logic                    wreg;
    logic [`CPU_RADDR_W-1:0] waddr;
    logic [`CPU_XLEN-1:0]    wdata;
    logic                    is_load;
  } fwd_t;

  typedef struct packed {
    logic                    valid;
    logic [`CPU_XLEN-1:0]    pc;
    logic [`CPU_XLEN-1:0]    instr;
    logic                    wreg;
    logic [`CPU_RADDR_W-1:0] waddr;
    logic [`CPU_XLEN-1:0]    wdata;
  } wb_t;

endpackage

`default_nettype wire

// ==== hdl/rf_read_if.sv ====
`include "cpu_settings.svh"
`default_nettype none

interface rf_read_if;
  logic                    re1;
  logic [`CPU_RADDR_W-1:0] raddr1;
  logic [`CPU_XLEN-1:0]    rdata1;
  logic                    re2;
  logic [`CPU_RADDR_W-1:0] raddr2;
  logic [`CPU_XLEN-1:0]    rdata2;

  modport decode (
    output re1, raddr1, re2, raddr2,
    input  rdata1, rdata2
  );

  modport regfile (
    input  re1, raddr1, re2, raddr2,
    output rdata1, rdata2
  );
endinterface

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`include "cpu_settings.svh"
`default_nettype none

module fetch_unit (
  input  wire                  clk,
  input  wire                  rst_i,
  input  wire                  stall_i,
  input  wire                  branch_taken_i,
  input  wire [`CPU_XLEN-1:0]  branch_target_i,
  output logic [`CPU_XLEN-1:0] ram_raddr_o,
  output logic                 ram_en_o,
  output logic [`CPU_XLEN-1:0] if_pc_o,
  output logic                 if_valid_o
);

  logic [`CPU_XLEN-1:0] pc_q;        // Next sequential fetch address
  logic [`CPU_XLEN-1:0] flight_pc_q; // Address of the word returning now
  logic                 en_q;
  logic                 valid_q;

  // A stalled decode gets its own word back one cycle later
  assign ram_raddr_o = stall_i ? flight_pc_q : pc_q;
  assign ram_en_o    = en_q;
  assign if_pc_o     = flight_pc_q;
  assign if_valid_o  = valid_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      en_q        <= 1'b0;
      valid_q     <= 1'b0;
      pc_q        <= `CPU_RESET_PC;
      flight_pc_q <= `CPU_RESET_PC;
    end else begin
      en_q    <= 1'b1;
      valid_q <= en_q & ~branch_taken_i; // Squash the slot behind a taken branch
      if (en_q) begin
        flight_pc_q <= ram_raddr_o;
        if (branch_taken_i) begin
          pc_q <= branch_target_i;
        end else begin
          pc_q <= ram_raddr_o + `CPU_XLEN'd4;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`include "cpu_settings.svh"
`default_nettype none

module regfile (
  input  wire                    clk,
  input  wire                    rst_i,
  rf_read_if.regfile             rd,
  input  wire                    we_i,
  input  wire [`CPU_RADDR_W-1:0] waddr_i,
  input  wire [`CPU_XLEN-1:0]    wdata_i
);

  logic [`CPU_XLEN-1:0] regs_q [`CPU_NUM_REGS];

  function automatic logic [`CPU_XLEN-1:0] read_port(
    input logic                    re,
    input logic [`CPU_RADDR_W-1:0] addr,
    input logic [`CPU_XLEN-1:0]    stored,
    input logic                    we,
    input logic [`CPU_RADDR_W-1:0] waddr,
    input logic [`CPU_XLEN-1:0]    wdata
  );
    logic [`CPU_XLEN-1:0] value;
    value = stored;
    if (!re || addr == '0) begin
      value = '0;
    end else if (we && waddr == addr) begin
      value = wdata;                     // Write-through
    end
    return value;
  endfunction

  assign rd.rdata1 = read_port(rd.re1, rd.raddr1, regs_q[rd.raddr1], we_i, waddr_i, wdata_i);
  assign rd.rdata2 = read_port(rd.re2, rd.raddr2, regs_q[rd.raddr2], we_i, waddr_i, wdata_i);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;      // r0 never written
    end
  end

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`include "cpu_settings.svh"
`default_nettype none

module decode_stage (
  input  wire                  clk,
  input  wire                  rst_i,
  input  wire [`CPU_XLEN-1:0]  if_pc_i,
  input  wire [`CPU_XLEN-1:0]  if_instr_i,
  input  wire                  if_valid_i,
  rf_read_if.decode            rd,
  input  wire cpu_pkg::fwd_t   ex_fwd_i,
  input  wire cpu_pkg::fwd_t   mem_fwd_i,
  output logic                 stall_o,
  output logic                 branch_taken_o,
  output logic [`CPU_XLEN-1:0] branch_target_o,
  output cpu_pkg::id_ex_t      id_ex_o
);
  import cpu_pkg::*;

  opcode_e                 opcode;
  funct_e                  funct;
  logic [`CPU_RADDR_W-1:0] rs_addr;
  logic [`CPU_RADDR_W-1:0] rt_addr;
  logic [`CPU_RADDR_W-1:0] rd_addr;
  logic [`CPU_RADDR_W-1:0] waddr;
  logic [`CPU_XLEN-1:0]    imm_sext;
  logic [`CPU_XLEN-1:0]    imm_zext;
  logic [`CPU_XLEN-1:0]    imm_b;
  logic [`CPU_XLEN-1:0]    pc_plus4;
  logic [`CPU_XLEN-1:0]    rs_val;
  logic [`CPU_XLEN-1:0]    rt_val;
  alu_op_e                 alu_op;
  mem_op_e                 mem_op;
  logic                    use_rs;
  logic                    use_rt;
  logic                    use_imm;
  logic                    wreg;
  logic                    legal;
  logic                    is_beq;
  logic                    is_bne;
  logic                    is_j;
  logic                    issue;

  // Execute result is newest, then mem, then the regfile
  function automatic logic [`CPU_XLEN-1:0] resolve(
    input logic [`CPU_RADDR_W-1:0] addr,
    input logic [`CPU_XLEN-1:0]    rf_val,
    input fwd_t                    ex_f,
    input fwd_t                    mem_f
  );
    logic [`CPU_XLEN-1:0] value;
    value = rf_val;
    if (addr != '0) begin
      if (ex_f.wreg && ex_f.waddr == addr) begin
        value = ex_f.wdata;
      end else if (mem_f.wreg && mem_f.waddr == addr) begin
        value = mem_f.wdata;
      end
    end
    return value;
  endfunction

  // ################################################
  // Field extraction and decode
  // ################################################
  assign opcode   = opcode_e'(if_instr_i[31:26]);
  assign funct    = funct_e'(if_instr_i[5:0]);
  assign rs_addr  = if_instr_i[25:21];
  assign rt_addr  = if_instr_i[20:16];
  assign rd_addr  = if_instr_i[15:11];
  assign imm_sext = {{(`CPU_XLEN-16){if_instr_i[15]}}, if_instr_i[15:0]};
  assign imm_zext = {{(`CPU_XLEN-16){1'b0}}, if_instr_i[15:0]};
  assign pc_plus4 = if_pc_i + `CPU_XLEN'd4;

  always_comb begin
    alu_op  = ALU_ADD;
    mem_op  = MEM_NONE;
    use_rs  = 1'b0;
    use_rt  = 1'b0;
    use_imm = 1'b1;
    imm_b   = imm_sext;
    wreg    = 1'b0;
    waddr   = rt_addr;
    legal   = 1'b1;
    is_beq  = 1'b0;
    is_bne  = 1'b0;
    is_j    = 1'b0;
    case (opcode)
      OP_SPECIAL: begin
        use_rs  = 1'b1;
        use_rt  = 1'b1;
        use_imm = 1'b0;
        wreg    = 1'b1;
        waddr   = rd_addr;
        case (funct)
          FN_ADDU: alu_op = ALU_ADD;
          FN_SUBU: alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_XOR:  alu_op = ALU_XOR;
          FN_SLT:  alu_op = ALU_SLT;
          default: legal  = 1'b0;
        endcase
      end
      OP_ADDIU: begin
        use_rs = 1'b1;
        wreg   = 1'b1;
      end
      OP_ORI: begin
        use_rs = 1'b1;
        wreg   = 1'b1;
        alu_op = ALU_OR;
        imm_b  = imm_zext;
      end
      OP_LUI: begin
        wreg   = 1'b1;
        alu_op = ALU_LUI;
        imm_b  = imm_zext;
      end
      OP_LW: begin
        use_rs = 1'b1;
        wreg   = 1'b1;
        mem_op = MEM_LOAD;
      end
      OP_SW: begin
        use_rs = 1'b1;
        use_rt = 1'b1;
        mem_op = MEM_STORE;
      end
      OP_BEQ: begin
        use_rs = 1'b1;
        use_rt = 1'b1;
        is_beq = 1'b1;
      end
      OP_BNE: begin
        use_rs = 1'b1;
        use_rt = 1'b1;
        is_bne = 1'b1;
      end
      OP_J:    is_j  = 1'b1;
      default: legal = 1'b0;
    endcase
  end

  // ################################################
  // Operands, load-use hazard and branches
  // ################################################
  assign rd.re1    = use_rs;
  assign rd.raddr1 = rs_addr;
  assign rd.re2    = use_rt;
  assign rd.raddr2 = rt_addr;

  assign rs_val = resolve(rs_addr, rd.rdata1, ex_fwd_i, mem_fwd_i);
  assign rt_val = resolve(rt_addr, rd.rdata2, ex_fwd_i, mem_fwd_i);

  // Load data is not ready until the load reaches mem
  assign stall_o = if_valid_i && ex_fwd_i.is_load && ex_fwd_i.waddr != '0 &&
                   ((use_rs && ex_fwd_i.waddr == rs_addr) ||
                    (use_rt && ex_fwd_i.waddr == rt_addr));

  assign branch_taken_o = if_valid_i && !stall_o &&
                          ((is_beq && rs_val == rt_val) ||
                           (is_bne && rs_val != rt_val) || is_j);

  assign branch_target_o = is_j ? {pc_plus4[`CPU_XLEN-1:28], if_instr_i[25:0], 2'b00}
                                : pc_plus4 + {imm_sext[`CPU_XLEN-3:0], 2'b00};

  // ################################################
  // ID/EX register
  // ################################################
  assign issue = if_valid_i && legal && !stall_o; // Otherwise a bubble

  always_ff @(posedge clk) begin
    id_ex_o.valid      <= issue;
    id_ex_o.pc         <= if_pc_i;
    id_ex_o.instr      <= if_instr_i;
    id_ex_o.alu_op     <= alu_op;
    id_ex_o.mem_op     <= mem_op;
    id_ex_o.op_a       <= rs_val;
    id_ex_o.op_b       <= use_imm ? imm_b : rt_val;
    id_ex_o.store_data <= rt_val;
    id_ex_o.wreg       <= issue && wreg;
    id_ex_o.waddr      <= waddr;
    if (rst_i) begin
      id_ex_o.valid <= 1'b0;
      id_ex_o.wreg  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`include "cpu_settings.svh"
`default_nettype none

module execute_stage (
  input  wire                    clk,
  input  wire                    rst_i,
  input  wire cpu_pkg::id_ex_t   id_ex_i,
  output cpu_pkg::fwd_t          ex_fwd_o,
  output cpu_pkg::ex_mem_t       ex_mem_o
);
  import cpu_pkg::*;

  logic [`CPU_XLEN-1:0] sum;
  logic [`CPU_XLEN-1:0] result;
  logic                 slt;

  assign sum = id_ex_i.op_a + id_ex_i.op_b;
  assign slt = $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b);

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD: result = sum;
      ALU_SUB: result = id_ex_i.op_a - id_ex_i.op_b;
      ALU_AND: result = id_ex_i.op_a & id_ex_i.op_b;
      ALU_OR:  result = id_ex_i.op_a | id_ex_i.op_b;
      ALU_XOR: result = id_ex_i.op_a ^ id_ex_i.op_b;
      ALU_SLT: result = {{(`CPU_XLEN-1){1'b0}}, slt};
      ALU_LUI: result = {id_ex_i.op_b[15:0], 16'h0000};
      default: result = sum;
    endcase
  end

  // Published to decode in the same cycle
  always_comb begin
    ex_fwd_o.wreg    = id_ex_i.wreg;
    ex_fwd_o.waddr   = id_ex_i.waddr;
    ex_fwd_o.wdata   = result;
    ex_fwd_o.is_load = id_ex_i.valid && id_ex_i.wreg && id_ex_i.mem_op == MEM_LOAD;
  end

  always_ff @(posedge clk) begin
    ex_mem_o.valid      <= id_ex_i.valid;
    ex_mem_o.pc         <= id_ex_i.pc;
    ex_mem_o.instr      <= id_ex_i.instr;
    ex_mem_o.mem_op     <= id_ex_i.mem_op;
    ex_mem_o.result     <= (id_ex_i.mem_op == MEM_NONE) ? result : sum; // Address for LW/SW
    ex_mem_o.store_data <= id_ex_i.store_data;
    ex_mem_o.wreg       <= id_ex_i.wreg;
    ex_mem_o.waddr      <= id_ex_i.waddr;
    if (rst_i) begin
      ex_mem_o.valid <= 1'b0;
      ex_mem_o.wreg  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mem_stage.sv ====
`include "cpu_settings.svh"
`default_nettype none

module mem_stage (
  input  wire                      clk,
  input  wire                      rst_i,
  input  wire cpu_pkg::ex_mem_t    ex_mem_i,
  input  wire [`CPU_XLEN-1:0]      dram_data_i,
  output logic [`CPU_XLEN-1:0]     dram_addr_o,
  output logic [`CPU_XLEN-1:0]     dram_data_o,
  output logic                     dram_we_o,
  output logic [`CPU_XLEN/8-1:0]   dram_sel_o,
  output logic                     dram_ce_o,
  output cpu_pkg::fwd_t            mem_fwd_o,
  output cpu_pkg::wb_t             wb_o
);
  import cpu_pkg::*;

  logic                 is_load;
  logic [`CPU_XLEN-1:0] wdata;

  assign is_load = ex_mem_i.valid && ex_mem_i.mem_op == MEM_LOAD;

  assign dram_ce_o   = ex_mem_i.valid && ex_mem_i.mem_op != MEM_NONE;
  assign dram_we_o   = ex_mem_i.valid && ex_mem_i.mem_op == MEM_STORE;
  assign dram_sel_o  = dram_ce_o ? '1 : '0; // Word accesses only
  assign dram_addr_o = ex_mem_i.result;
  assign dram_data_o = ex_mem_i.store_data;

  assign wdata = is_load ? dram_data_i : ex_mem_i.result;

  always_comb begin
    mem_fwd_o.wreg    = ex_mem_i.wreg;
    mem_fwd_o.waddr   = ex_mem_i.waddr;
    mem_fwd_o.wdata   = wdata;
    mem_fwd_o.is_load = is_load;
  end

  // MEM/WB register that also drives the commit port
  always_ff @(posedge clk) begin
    wb_o.valid <= ex_mem_i.valid;
    wb_o.pc    <= ex_mem_i.pc;
    wb_o.instr <= ex_mem_i.instr;
    wb_o.wreg  <= ex_mem_i.wreg;
    wb_o.waddr <= ex_mem_i.waddr;
    wb_o.wdata <= wdata;
    if (rst_i) begin
      wb_o.valid <= 1'b0;
      wb_o.wreg  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cpu_top.sv ====
`include "cpu_settings.svh"
`default_nettype none

module cpu_top (
  input  wire                      clk,
  input  wire                      rst_i,
  input  wire [`CPU_XLEN-1:0]      ram_rdata_i,
  input  wire [`CPU_XLEN-1:0]      dram_data_i,
  output logic [`CPU_XLEN-1:0]     ram_raddr_o,
  output logic                     ram_en_o,
  output logic [`CPU_XLEN-1:0]     dram_addr_o,
  output logic [`CPU_XLEN-1:0]     dram_data_o,
  output logic                     dram_we_o,
  output logic [`CPU_XLEN/8-1:0]   dram_sel_o,
  output logic                     dram_ce_o,
  output logic                     commit_valid_o,
  output logic [`CPU_XLEN-1:0]     commit_pc_o,
  output logic [`CPU_XLEN-1:0]     commit_instr_o,
  output logic                     commit_wreg_o,
  output logic [`CPU_RADDR_W-1:0]  commit_waddr_o,
  output logic [`CPU_XLEN-1:0]     commit_wdata_o,
  output logic                     branch_taken_o
);
  import cpu_pkg::*;

  logic [`CPU_XLEN-1:0] if_pc;
  logic                 if_valid;
  logic                 stall;
  logic                 branch_taken;
  logic [`CPU_XLEN-1:0] branch_target;
  id_ex_t               id_ex;
  ex_mem_t              ex_mem;
  fwd_t                 ex_fwd;
  fwd_t                 mem_fwd;
  wb_t                  wb;

  rf_read_if rf_rd ();

  assign branch_taken_o = branch_taken;

  assign commit_valid_o = wb.valid;
  assign commit_pc_o    = wb.pc;
  assign commit_instr_o = wb.instr;
  assign commit_wreg_o  = wb.wreg;
  assign commit_waddr_o = wb.waddr;
  assign commit_wdata_o = wb.wdata;

  fetch_unit u_fetch (
    .clk             (clk),
    .rst_i           (rst_i),
    .stall_i         (stall),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .ram_raddr_o     (ram_raddr_o),
    .ram_en_o        (ram_en_o),
    .if_pc_o         (if_pc),
    .if_valid_o      (if_valid)
  );

  decode_stage u_decode (
    .clk             (clk),
    .rst_i           (rst_i),
    .if_pc_i         (if_pc),
    .if_instr_i      (ram_rdata_i),
    .if_valid_i      (if_valid),
    .rd              (rf_rd.decode),
    .ex_fwd_i        (ex_fwd),
    .mem_fwd_i       (mem_fwd),
    .stall_o         (stall),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target),
    .id_ex_o         (id_ex)
  );

  execute_stage u_execute (
    .clk      (clk),
    .rst_i    (rst_i),
    .id_ex_i  (id_ex),
    .ex_fwd_o (ex_fwd),
    .ex_mem_o (ex_mem)
  );

  mem_stage u_mem (
    .clk         (clk),
    .rst_i       (rst_i),
    .ex_mem_i    (ex_mem),
    .dram_data_i (dram_data_i),
    .dram_addr_o (dram_addr_o),
    .dram_data_o (dram_data_o),
    .dram_we_o   (dram_we_o),
    .dram_sel_o  (dram_sel_o),
    .dram_ce_o   (dram_ce_o),
    .mem_fwd_o   (mem_fwd),
    .wb_o        (wb)
  );

  regfile u_regfile (
    .clk     (clk),
    .rst_i   (rst_i),
    .rd      (rf_rd.regfile),
    .we_i    (wb.wreg),
    .waddr_i (wb.waddr),
    .wdata_i (wb.wdata)
  );

endmodule

`default_nettype wire

// ==== bench/cpu_tb_mem.sv ====
`default_nettype none

module cpu_tb_mem (
  input  wire         clk,
  input  wire         ram_en_i,
  input  wire  [31:0] ram_raddr_i,
  output logic [31:0] ram_rdata_o,
  input  wire         dram_ce_i,
  input  wire         dram_we_i,
  input  wire  [3:0]  dram_sel_i,
  input  wire  [31:0] dram_addr_i,
  input  wire  [31:0] dram_wdata_i,
  output logic [31:0] dram_rdata_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import cpu_pkg::*;

  localparam int ROM_WORDS = 64;
  localparam int RAM_WORDS = 64;

  logic [31:0] rom [ROM_WORDS];
  int          tag [ROM_WORDS];                 // Test number of each word
  logic [31:0] ram [RAM_WORDS];
  int          prog_len;
  logic [31:0] lfsr_q;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
  endfunction

  task automatic rand16(output logic [15:0] v);
    v = '0;
    repeat (16) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[14:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [31:0] r_type(input funct_e fn, input logic [4:0] rd,
                                         input logic [4:0] rs, input logic [4:0] rt);
    return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] i_type(input opcode_e op, input logic [4:0] rt,
                                         input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic emit(input logic [31:0] ins, input int t);
    rom[prog_len] = ins;
    tag[prog_len] = t;
    prog_len++;
  endtask

  // ################################################
  // Memory models
  // ################################################
  always @(posedge clk) begin
    if (ram_en_i) begin
      ram_rdata_o <= (ram_raddr_i[31:8] == '0) ? rom[ram_raddr_i[7:2]] : '0; // Zero is a bubble
    end
  end

  assign dram_rdata_o = ram[dram_addr_i[7:2]];

  always @(posedge clk) begin
    if (dram_ce_i && dram_we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (dram_sel_i[b]) begin
          ram[dram_addr_i[7:2]][8*b +: 8] <= dram_wdata_i[8*b +: 8];
        end
      end
    end
  end

  // ################################################
  // Program
  // ################################################
  initial begin
    logic [15:0] v;
    ram_rdata_o = '0;
    lfsr_q      = 32'h5a336a19;
    prog_len    = 0;
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = '0;
      tag[i] = 0;
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      ram[i] = 32'(i * 4) ^ 32'hc3a5_0f69;
    end
    // Dependent ALU chain
    rand16(v);
    emit(i_type(OP_LUI, 5'd1, 5'd0, v), 2);
    rand16(v);
    emit(i_type(OP_ORI, 5'd1, 5'd1, v), 2);
    rand16(v);
    emit(i_type(OP_LUI, 5'd2, 5'd0, v), 2);
    rand16(v);
    emit(i_type(OP_ORI, 5'd2, 5'd2, v), 2);
    emit(r_type(FN_ADDU, 5'd3, 5'd1, 5'd2), 2);
    emit(r_type(FN_SUBU, 5'd4, 5'd3, 5'd1), 2);
    emit(r_type(FN_AND, 5'd5, 5'd4, 5'd3), 2);
    emit(r_type(FN_OR, 5'd6, 5'd5, 5'd2), 2);
    emit(r_type(FN_XOR, 5'd7, 5'd6, 5'd4), 2);
    emit(r_type(FN_SLT, 5'd8, 5'd7, 5'd1), 2);
    rand16(v);
    emit(i_type(OP_ADDIU, 5'd9, 5'd8, v), 2);
    rand16(v);
    emit(i_type(OP_ORI, 5'd10, 5'd9, v), 2);
    rand16(v);
    emit(i_type(OP_LUI, 5'd11, 5'd0, v), 2);
    emit(r_type(FN_ADDU, 5'd12, 5'd11, 5'd10), 2);
    // Store then load of one word
    emit(i_type(OP_ADDIU, 5'd20, 5'd0, 16'h0040), 3);
    emit(i_type(OP_SW, 5'd12, 5'd20, 16'd4), 3);
    emit(i_type(OP_LW, 5'd13, 5'd20, 16'd4), 3);
    emit(i_type(OP_ORI, 5'd21, 5'd0, 16'd3), 3);
    emit(r_type(FN_ADDU, 5'd22, 5'd21, 5'd13), 3);
    // Load-use pairs
    emit(i_type(OP_SW, 5'd3, 5'd20, 16'd8), 4);
    emit(i_type(OP_LW, 5'd14, 5'd20, 16'd8), 4);
    emit(r_type(FN_ADDU, 5'd15, 5'd14, 5'd1), 4);
    emit(i_type(OP_LW, 5'd16, 5'd20, 16'd12), 4);
    emit(r_type(FN_SUBU, 5'd17, 5'd16, 5'd15), 4);
    // Branches that each skip one word
    emit(i_type(OP_BEQ, 5'd1, 5'd1, 16'd1), 5);
    emit(i_type(OP_ADDIU, 5'd23, 5'd0, 16'd1), 5);
    emit(i_type(OP_BNE, 5'd2, 5'd1, 16'd1), 5);
    emit(i_type(OP_ADDIU, 5'd23, 5'd0, 16'd2), 5);
    emit(i_type(OP_BEQ, 5'd2, 5'd1, 16'd1), 5);     // Falls through unless r1 equals r2
    emit(i_type(OP_ADDIU, 5'd24, 5'd0, 16'd5), 5);
    emit({OP_J, 26'(prog_len + 2)}, 5);
    emit(i_type(OP_ADDIU, 5'd25, 5'd0, 16'd6), 5);
    emit(i_type(OP_ADDIU, 5'd26, 5'd0, 16'd7), 5);
  end

endmodule

`default_nettype wire

// ==== bench/cpu_tb.sv ====
`default_nettype none

module cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cpu_pkg::*;

  logic        clk;
  logic        rst_i;
  logic [31:0] ram_rdata, dram_rdata, ram_raddr, dram_addr, dram_wdata;
  logic        ram_en, dram_we, dram_ce, branch_taken;
  logic [3:0]  dram_sel;
  logic        commit_valid, commit_wreg;
  logic [31:0] commit_pc, commit_instr, commit_wdata;
  logic [4:0]  commit_waddr;

  // Shadow model results, in program order
  logic [31:0] exp_pc [128];
  logic [31:0] exp_instr [128];
  logic        exp_wreg [128];
  logic [4:0]  exp_waddr [128];
  logic [31:0] exp_wdata [128];
  int          exp_tag [128];
  logic [31:0] st_addr [32];
  logic [31:0] st_data [32];
  int          st_tag [32];
  int          exp_n, st_n, exp_taken, last_idx [7], test_err [7];
  int          commit_idx, st_idx, taken_cnt, cycles, limit, errors, checks, t;
  logic        rst_q, first_fetch_seen;
  string       test_name [7];

  cpu_top UUT (
    .clk (clk), .rst_i (rst_i), .ram_rdata_i (ram_rdata), .dram_data_i (dram_rdata),
    .ram_raddr_o (ram_raddr), .ram_en_o (ram_en), .dram_addr_o (dram_addr),
    .dram_data_o (dram_wdata), .dram_we_o (dram_we), .dram_sel_o (dram_sel),
    .dram_ce_o (dram_ce), .commit_valid_o (commit_valid), .commit_pc_o (commit_pc),
    .commit_instr_o (commit_instr), .commit_wreg_o (commit_wreg),
    .commit_waddr_o (commit_waddr), .commit_wdata_o (commit_wdata),
    .branch_taken_o (branch_taken)
  );

  cpu_tb_mem mem (
    .clk (clk), .ram_en_i (ram_en), .ram_raddr_i (ram_raddr), .ram_rdata_o (ram_rdata),
    .dram_ce_i (dram_ce), .dram_we_i (dram_we), .dram_sel_i (dram_sel),
    .dram_addr_i (dram_addr), .dram_wdata_i (dram_wdata), .dram_rdata_o (dram_rdata)
  );

  task automatic note_error(input int tn);
    errors++;
    test_err[tn]++;
  endtask

  task automatic report_test(input int tn);
    $display("test %s done, %0d errors", test_name[tn], test_err[tn]);
  endtask

  // ################################################
  // Shadow model with MIPS semantics and no delay slot
  // ################################################
  task automatic run_shadow();
    logic [31:0] regs [32];
    logic [31:0] dmem [64];
    logic [31:0] pc, nxt, ins, a, b, simm, res, addr;
    logic [4:0]  wa;
    logic        w;
    int          steps;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      dmem[i] = mem.ram[i];
    end
    pc    = 32'd0;
    steps = 0;
    while (int'(pc[31:2]) < mem.prog_len && steps < 200) begin
      ins  = mem.rom[pc[7:2]];
      a    = regs[ins[25:21]];
      b    = regs[ins[20:16]];
      simm = {{16{ins[15]}}, ins[15:0]};
      addr = a + simm;
      nxt  = pc + 32'd4;
      w    = 1'b0;
      wa   = ins[20:16];
      res  = '0;
      case (ins[31:26])
        OP_SPECIAL: begin
          w  = 1'b1;
          wa = ins[15:11];
          case (ins[5:0])
            FN_ADDU: res = a + b;
            FN_SUBU: res = a - b;
            FN_AND:  res = a & b;
            FN_OR:   res = a | b;
            FN_XOR:  res = a ^ b;
            FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
            default: w = 1'b0;
          endcase
        end
        OP_ADDIU: begin
          w   = 1'b1;
          res = addr;
        end
        OP_ORI: begin
          w   = 1'b1;
          res = a | {16'd0, ins[15:0]};
        end
        OP_LUI: begin
          w   = 1'b1;
          res = {ins[15:0], 16'd0};
        end
        OP_LW: begin
          w   = 1'b1;
          res = dmem[addr[7:2]];
        end
        OP_SW: begin
          dmem[addr[7:2]] = b;
          st_addr[st_n]   = addr;
          st_data[st_n]   = b;
          st_tag[st_n]    = mem.tag[pc[7:2]];
          st_n++;
        end
        OP_BEQ: if (a == b) nxt = pc + 32'd4 + {simm[29:0], 2'b00};
        OP_BNE: if (a != b) nxt = pc + 32'd4 + {simm[29:0], 2'b00};
        OP_J:   nxt = {nxt[31:28], ins[25:0], 2'b00};
        default: ;
      endcase
      if (nxt != pc + 32'd4) exp_taken++;
      if (w && wa != 5'd0) regs[wa] = res;
      exp_pc[exp_n]    = pc;
      exp_instr[exp_n] = ins;
      exp_wreg[exp_n]  = w;
      exp_waddr[exp_n] = wa;
      exp_wdata[exp_n] = res;
      exp_tag[exp_n]   = mem.tag[pc[7:2]];
      last_idx[mem.tag[pc[7:2]]] = exp_n;
      exp_n++;
      pc = nxt;
      steps++;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(negedge clk) cycles++;

  // ################################################
  // Checks sampled at the falling edge
  // ################################################
  always @(negedge clk) begin
    if (rst_i || rst_q) begin
      assert (!commit_valid && !ram_en && !dram_ce && !dram_we) else begin
        $display("Core outputs were active during or right after reset");
        note_error(1);
      end
    end
    rst_q = rst_i;
    if (!rst_i && ram_en && !first_fetch_seen) begin
      first_fetch_seen = 1'b1;
      assert (ram_raddr == 32'd0) else begin
        $display("FAIL ram_raddr_o: got %h expected %h", ram_raddr, 32'd0);
        note_error(1);
      end
      report_test(1);
    end
    if (!rst_i && branch_taken) taken_cnt++;
    if (!rst_i && dram_we) begin
      if (st_idx >= st_n) begin
        $display("Unexpected store to address %h", dram_addr);
        note_error(3);
      end else begin
        assert (dram_sel == 4'hf) else begin
          $display("FAIL dram_sel_o: got %h expected %h", dram_sel, 4'hf);
          note_error(st_tag[st_idx]);
        end
        assert (dram_addr == st_addr[st_idx] && dram_wdata == st_data[st_idx]) else begin
          $display("FAIL dram_data_o: got %h at %h expected %h at %h",
                   dram_wdata, dram_addr, st_data[st_idx], st_addr[st_idx]);
          note_error(st_tag[st_idx]);
        end
        st_idx++;
      end
    end
    if (!rst_i && commit_valid) begin
      if (commit_idx >= exp_n) begin
        $display("Unexpected commit at pc %h after the program ended", commit_pc);
        note_error(6);
      end else begin
        t = exp_tag[commit_idx];
        checks++;
        assert (commit_pc == exp_pc[commit_idx]) else begin
          $display("FAIL commit_pc_o: got %h expected %h", commit_pc, exp_pc[commit_idx]);
          note_error(t);
        end
        assert (commit_instr == exp_instr[commit_idx]) else begin
          $display("FAIL commit_instr_o: got %h expected %h", commit_instr,
                   exp_instr[commit_idx]);
          note_error(t);
        end
        assert (commit_wreg == exp_wreg[commit_idx]) else begin
          $display("FAIL commit_wreg_o: got %h expected %h", commit_wreg,
                   exp_wreg[commit_idx]);
          note_error(t);
        end
        if (exp_wreg[commit_idx]) begin
          assert (commit_waddr == exp_waddr[commit_idx]) else begin
            $display("FAIL commit_waddr_o: got %h expected %h", commit_waddr,
                     exp_waddr[commit_idx]);
            note_error(t);
          end
          assert (commit_wdata == exp_wdata[commit_idx]) else begin
            $display("FAIL commit_wdata_o: got %h expected %h", commit_wdata,
                     exp_wdata[commit_idx]);
            note_error(t);
          end
        end
        if (commit_idx == last_idx[t]) report_test(t);
        commit_idx++;
      end
    end
  end

  initial begin
    rst_i = 1'b1;
    rst_q = 1'b0;
    first_fetch_seen = 1'b0;
    test_name = '{"none", "reset", "alu_chain", "store_load", "load_use", "branches",
                  "completion"};
    for (int i = 0; i < 7; i++) begin
      last_idx[i] = -1;
      test_err[i] = 0;
    end
    #1;
    run_shadow();                                    // Program is built at time zero
    limit = 4 * mem.prog_len + 50;
    repeat (8) @(posedge clk);
    #2 rst_i = 1'b0;
    while (commit_idx < exp_n && cycles < limit) @(posedge clk);
    if (cycles >= limit) begin
      $display("Timeout: only %0d of %0d instructions committed", commit_idx, exp_n);
      note_error(6);
    end
    repeat (6) @(posedge clk);                       // Catch stray commits
    assert (commit_idx == exp_n) else begin
      $display("FAIL commit count: got %h expected %h", commit_idx, exp_n);
      note_error(6);
    end
    assert (st_idx == st_n) else begin
      $display("FAIL store count: got %h expected %h", st_idx, st_n);
      note_error(6);
    end
    assert (taken_cnt == exp_taken) else begin
      $display("FAIL branch_taken_o pulses: got %h expected %h", taken_cnt, exp_taken);
      note_error(6);
    end
    report_test(6);
    $display("6 tests, %0d commits checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cpu_top.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/rf_read_if.sv
hdl/fetch_unit.sv
hdl/regfile.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/cpu_top.sv
bench/cpu_tb_mem.sv
bench/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb -f cpu_top.f -o cpu_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

output=$(./obj_dir/cpu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
  exit 0
fi
exit 1
